/* source/mem_sys_pkg.sv */
// mem_sys_pkg: address fields, cache geometry, memory timing and client id of the memory subsystem
package mem_sys_pkg;

   // word address is {tag, index, offset}
   localparam int ADDR_W   = 12;
   localparam int DATA_W   = 16;
   localparam int OFFSET_W = 2;
   localparam int INDEX_W  = 6;
   localparam int TAG_W    = 4;

   localparam int LINE_WORDS = 4;

   // low address bits pick the bank, so one line covers every bank
   localparam int NUM_BANKS = 4;

   // cycles from an accepted read to its data
   localparam int MEM_LAT   = 3;
   // bank lockout after an access, accept cycle included
   localparam int BANK_BUSY = 4;

   // 0 is inst, 1 is data
   typedef logic client_id_t;

endpackage

/* source/cache_way.sv */
// cache_way: tag, valid, dirty and data storage of one cache way with tag compare
module cache_way (
   input  logic                             clk,
   input  logic                             rst,
   input  logic [mem_sys_pkg::INDEX_W-1:0]  index,
   input  logic [mem_sys_pkg::OFFSET_W-1:0] offset,
   input  logic [mem_sys_pkg::TAG_W-1:0]    tag_in,
   input  logic [mem_sys_pkg::DATA_W-1:0]   wdata,
   input  logic                             wr_en,
   input  logic                             fill_en,
   input  logic                             set_dirty,
   input  logic                             set_valid,
   output logic [mem_sys_pkg::DATA_W-1:0]   rdata,
   output logic [mem_sys_pkg::TAG_W-1:0]    tag_out,
   output logic                             valid,
   output logic                             dirty,
   output logic                             hit
);
   import mem_sys_pkg::*;

   localparam int SETS = 2 ** INDEX_W;

   logic [DATA_W-1:0] data_q [SETS][LINE_WORDS];
   logic [TAG_W-1:0]  tag_q [SETS];
   logic [SETS-1:0]   valid_q;
   logic [SETS-1:0]   dirty_q;

   always_ff @(posedge clk) begin
      if (wr_en || fill_en) begin
         data_q[index][offset] <= wdata;
      end
      if (set_valid) begin
         tag_q[index] <= tag_in;
      end
   end

   // a fill brings in a clean line
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else begin
         if (set_valid) begin
            valid_q[index] <= 1'b1;
         end
         if (fill_en) begin
            dirty_q[index] <= 1'b0;
         end else if (set_dirty) begin
            dirty_q[index] <= 1'b1;
         end
      end
   end

   assign rdata   = data_q[index][offset];
   assign tag_out = tag_q[index];
   assign valid   = valid_q[index];
   assign dirty   = dirty_q[index];
   assign hit     = valid & (tag_out == tag_in);

endmodule

/* source/cache_ctrl.sv */
// cache_ctrl: miss FSM for hit response, victim choice, write-back, line fill and LRU update
module cache_ctrl (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                req_valid,
   input  logic                                req_write,
   input  logic                                hit0,
   input  logic                                hit1,
   input  logic                                valid0,
   input  logic                                valid1,
   input  logic                                dirty0,
   input  logic                                dirty1,
   input  logic                                lru,
   input  logic                                m_ready,
   input  logic                                m_rvalid,
   output logic                                req_ready,
   output logic                                resp_valid,
   output logic                                resp_hit,
   output logic                                way_sel,
   output logic [1:0][mem_sys_pkg::OFFSET_W-1:0] word_sel,
   output logic                                wr_en0,
   output logic                                wr_en1,
   output logic                                fill_en0,
   output logic                                fill_en1,
   output logic                                m_valid,
   output logic                                m_write,
   output logic                                tag_sel_victim,
   output logic                                lru_update
);
   import mem_sys_pkg::*;

   typedef enum logic [2:0] {
      st_idle,
      st_respond,
      st_write_back,
      st_fill_issue,
      st_fill_wait,
      st_complete
   } state_t;

   state_t              state_q;
   state_t              state_d;
   logic [OFFSET_W-1:0] issue_q;
   logic [OFFSET_W-1:0] ret_q;
   logic                victim_q;
   logic                victim_d;
   logic                hit_any;
   logic                issue_fire;
   logic                last_issue;
   logic                last_ret;

   assign hit_any    = hit0 | hit1;
   assign issue_fire = m_valid & m_ready;
   assign last_issue = (issue_q == OFFSET_W'(LINE_WORDS - 1));
   assign last_ret   = (ret_q == OFFSET_W'(LINE_WORDS - 1));

   // an empty way first, then the least recently used one
   always_comb begin
      if (!valid0) begin
         victim_d = 1'b0;
      end else if (!valid1) begin
         victim_d = 1'b1;
      end else begin
         victim_d = lru;
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle: begin
            if (req_valid) begin
               state_d = st_respond;
            end
         end
         st_respond: begin
            if (hit_any) begin
               state_d = st_idle;
            end else if (victim_d ? dirty1 : dirty0) begin
               state_d = st_write_back;
            end else begin
               state_d = st_fill_issue;
            end
         end
         st_write_back: begin
            if (issue_fire && last_issue) begin
               state_d = st_fill_issue;
            end
         end
         st_fill_issue: begin
            if (issue_fire && last_issue) begin
               state_d = st_fill_wait;
            end
         end
         // the last return always lands after the last issue
         st_fill_wait: begin
            if (m_rvalid && last_ret) begin
               state_d = st_complete;
            end
         end
         default: begin
            state_d = st_idle;
         end
      endcase
   end

   // issue and return counters wrap back to word 0 after a line
   always_ff @(posedge clk) begin
      if (rst) begin
         state_q  <= st_idle;
         issue_q  <= '0;
         ret_q    <= '0;
         victim_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_q == st_respond && !hit_any) begin
            victim_q <= victim_d;
         end
         if (issue_fire) begin
            issue_q <= issue_q + 1'b1;
         end
         if (m_rvalid) begin
            ret_q <= ret_q + 1'b1;
         end
      end
   end

   assign req_ready      = (state_q == st_idle);
   assign resp_hit       = (state_q == st_respond) & hit_any;
   assign resp_valid     = resp_hit | (state_q == st_complete);
   assign lru_update     = resp_valid;
   assign way_sel        = (state_q == st_respond) ? hit1 : victim_q;
   assign wr_en0         = resp_valid & req_write & ~way_sel;
   assign wr_en1         = resp_valid & req_write & way_sel;
   assign fill_en0       = m_rvalid & ~victim_q;
   assign fill_en1       = m_rvalid & victim_q;
   assign m_valid        = (state_q == st_write_back) | (state_q == st_fill_issue);
   assign m_write        = (state_q == st_write_back);
   assign tag_sel_victim = (state_q == st_write_back);
   // word 0 goes to memory, word 1 is the fill slot in the array
   assign word_sel[0]    = issue_q;
   assign word_sel[1]    = ret_q;

endmodule

/* source/mem_system.sv */
// mem_system: two-way write-back cache for one client in front of the shared memory port
module mem_system (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           req_valid,
   input  logic                           req_write,
   input  logic [mem_sys_pkg::ADDR_W-1:0] req_addr,
   input  logic [mem_sys_pkg::DATA_W-1:0] req_wdata,
   output logic                           req_ready,
   output logic                           resp_valid,
   output logic [mem_sys_pkg::DATA_W-1:0] resp_rdata,
   output logic                           resp_hit,
   output logic                           m_valid,
   output logic                           m_write,
   output logic [mem_sys_pkg::ADDR_W-1:0] m_addr,
   output logic [mem_sys_pkg::DATA_W-1:0] m_wdata,
   input  logic                           m_ready,
   input  logic                           m_rvalid,
   input  logic [mem_sys_pkg::DATA_W-1:0] m_rdata
);
   import mem_sys_pkg::*;

   logic [ADDR_W-1:0]        addr_q;
   logic [DATA_W-1:0]        wdata_q;
   logic                     write_q;
   logic [TAG_W-1:0]         req_tag;
   logic [INDEX_W-1:0]       req_index;
   logic [OFFSET_W-1:0]      req_offset;
   logic [OFFSET_W-1:0]      way_offset;
   logic [DATA_W-1:0]        way_wdata;
   logic [DATA_W-1:0]        rdata0;
   logic [DATA_W-1:0]        rdata1;
   logic [DATA_W-1:0]        sel_rdata;
   logic [TAG_W-1:0]         tag0;
   logic [TAG_W-1:0]         tag1;
   logic                     hit0, hit1, valid0, valid1, dirty0, dirty1;
   logic                     wr_en0, wr_en1, fill_en0, fill_en1;
   logic                     fill_last;
   logic                     way_sel;
   logic                     tag_sel_victim;
   logic                     lru_update;
   logic [1:0][OFFSET_W-1:0] word_sel;
   logic [2**INDEX_W-1:0]    lru_q;

   // request is held here for the whole miss
   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         addr_q  <= req_addr;
         wdata_q <= req_wdata;
         write_q <= req_write;
      end
   end

   assign {req_tag, req_index, req_offset} = addr_q;

   // lru bit names the way used less recently in its set
   always_ff @(posedge clk) begin
      if (rst) begin
         lru_q <= '0;
      end else if (lru_update) begin
         lru_q[req_index] <= ~way_sel;
      end
   end

   assign fill_last = (word_sel[1] == OFFSET_W'(LINE_WORDS - 1));
   assign way_wdata = (fill_en0 | fill_en1) ? m_rdata : wdata_q;

   always_comb begin
      if (tag_sel_victim) begin
         way_offset = word_sel[0];
      end else if (fill_en0 || fill_en1) begin
         way_offset = word_sel[1];
      end else begin
         way_offset = req_offset;
      end
   end

   cache_way way0 (
      .clk(clk), .rst(rst), .index(req_index), .offset(way_offset), .tag_in(req_tag),
      .wdata(way_wdata), .wr_en(wr_en0), .fill_en(fill_en0), .set_dirty(wr_en0),
      .set_valid(fill_en0 & fill_last), .rdata(rdata0), .tag_out(tag0),
      .valid(valid0), .dirty(dirty0), .hit(hit0)
   );

   cache_way way1 (
      .clk(clk), .rst(rst), .index(req_index), .offset(way_offset), .tag_in(req_tag),
      .wdata(way_wdata), .wr_en(wr_en1), .fill_en(fill_en1), .set_dirty(wr_en1),
      .set_valid(fill_en1 & fill_last), .rdata(rdata1), .tag_out(tag1),
      .valid(valid1), .dirty(dirty1), .hit(hit1)
   );

   cache_ctrl ctrl (
      .clk(clk), .rst(rst), .req_valid(req_valid), .req_write(write_q),
      .hit0(hit0), .hit1(hit1), .valid0(valid0), .valid1(valid1),
      .dirty0(dirty0), .dirty1(dirty1), .lru(lru_q[req_index]),
      .m_ready(m_ready), .m_rvalid(m_rvalid), .req_ready(req_ready),
      .resp_valid(resp_valid), .resp_hit(resp_hit), .way_sel(way_sel),
      .word_sel(word_sel), .wr_en0(wr_en0), .wr_en1(wr_en1),
      .fill_en0(fill_en0), .fill_en1(fill_en1), .m_valid(m_valid),
      .m_write(m_write), .tag_sel_victim(tag_sel_victim), .lru_update(lru_update)
   );

   // way_sel picks the hit way, or the victim during a miss
   assign sel_rdata  = way_sel ? rdata1 : rdata0;
   assign resp_rdata = write_q ? wdata_q : sel_rdata;
   assign m_wdata    = sel_rdata;
   assign m_addr     = {tag_sel_victim ? (way_sel ? tag1 : tag0) : req_tag,
                        req_index, word_sel[0]};

endmodule

/* source/mem_arbiter.sv */
// mem_arbiter: round-robin grant of two memory requesters with routing of read returns
module mem_arbiter (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           c0_valid,
   input  logic                           c0_write,
   input  logic [mem_sys_pkg::ADDR_W-1:0] c0_addr,
   input  logic [mem_sys_pkg::DATA_W-1:0] c0_wdata,
   output logic                           c0_ready,
   output logic                           c0_rvalid,
   output logic [mem_sys_pkg::DATA_W-1:0] c0_rdata,
   input  logic                           c1_valid,
   input  logic                           c1_write,
   input  logic [mem_sys_pkg::ADDR_W-1:0] c1_addr,
   input  logic [mem_sys_pkg::DATA_W-1:0] c1_wdata,
   output logic                           c1_ready,
   output logic                           c1_rvalid,
   output logic [mem_sys_pkg::DATA_W-1:0] c1_rdata,
   output logic                           valid,
   output logic                           write,
   output logic [mem_sys_pkg::ADDR_W-1:0] addr,
   output logic [mem_sys_pkg::DATA_W-1:0] wdata,
   input  logic                           ready,
   input  logic                           rvalid,
   input  logic [mem_sys_pkg::DATA_W-1:0] rdata
);
   import mem_sys_pkg::*;

   client_id_t               gnt;
   client_id_t               prio_q;
   client_id_t [MEM_LAT-1:0] route_q;

   // prio_q holds the client that lost last time
   always_comb begin
      if (c0_valid && c1_valid) begin
         gnt = prio_q;
      end else begin
         gnt = client_id_t'(c1_valid);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         prio_q  <= client_id_t'(0);
         route_q <= '0;
      end else begin
         if (valid && ready) begin
            prio_q <= ~gnt;
         end
         route_q <= {route_q[MEM_LAT-2:0], gnt};
      end
   end

   assign valid = c0_valid | c1_valid;
   assign write = gnt ? c1_write : c0_write;
   assign addr  = gnt ? c1_addr : c0_addr;
   assign wdata = gnt ? c1_wdata : c0_wdata;

   assign c0_ready  = ready & ~gnt;
   assign c1_ready  = ready & gnt;
   assign c0_rvalid = rvalid & ~route_q[MEM_LAT-1];
   assign c1_rvalid = rvalid & route_q[MEM_LAT-1];
   assign c0_rdata  = rdata;
   assign c1_rdata  = rdata;

endmodule

/* source/banked_mem.sv */
// banked_mem: four-bank word memory with per-bank busy timers and a fixed-latency read pipe
module banked_mem (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           valid,
   input  logic                           write,
   input  logic [mem_sys_pkg::ADDR_W-1:0] addr,
   input  logic [mem_sys_pkg::DATA_W-1:0] wdata,
   output logic                           ready,
   output logic                           rvalid,
   output logic [mem_sys_pkg::DATA_W-1:0] rdata
);
   import mem_sys_pkg::*;

   localparam int BANK_W = $clog2(NUM_BANKS);
   localparam int ROW_W  = ADDR_W - BANK_W;
   localparam int CNT_W  = $clog2(BANK_BUSY);

   logic [DATA_W-1:0]  bank_q [NUM_BANKS][2**ROW_W];
   logic [CNT_W-1:0]   busy_q [NUM_BANKS];
   logic [DATA_W-1:0]  rd_data_q [MEM_LAT];
   logic [MEM_LAT-1:0] rd_vld_q;
   logic [BANK_W-1:0]  bank;
   logic [ROW_W-1:0]   row;
   logic               accept;

   assign bank   = addr[BANK_W-1:0];
   assign row    = addr[ADDR_W-1:BANK_W];
   assign ready  = (busy_q[bank] == '0);
   assign accept = valid & ready;

   // timer loads on accept and counts down to free
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            busy_q[b] <= '0;
         end
      end else begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            if (accept && bank == BANK_W'(b)) begin
               busy_q[b] <= CNT_W'(BANK_BUSY - 1);
            end else if (busy_q[b] != '0) begin
               busy_q[b] <= busy_q[b] - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && write) begin
         bank_q[bank][row] <= wdata;
      end
      rd_data_q[0] <= bank_q[bank][row];
      for (int s = 1; s < MEM_LAT; s++) begin
         rd_data_q[s] <= rd_data_q[s-1];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_vld_q <= '0;
      end else begin
         rd_vld_q <= {rd_vld_q[MEM_LAT-2:0], accept & ~write};
      end
   end

   assign rvalid = rd_vld_q[MEM_LAT-1];
   assign rdata  = rd_data_q[MEM_LAT-1];

endmodule

/* source/mem_top.sv */
// mem_top: inst and data caches sharing one banked memory through a round-robin arbiter
module mem_top (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           inst_req_valid,
   input  logic                           inst_req_write,
   input  logic [mem_sys_pkg::ADDR_W-1:0] inst_req_addr,
   input  logic [mem_sys_pkg::DATA_W-1:0] inst_req_wdata,
   output logic                           inst_req_ready,
   output logic                           inst_resp_valid,
   output logic [mem_sys_pkg::DATA_W-1:0] inst_resp_rdata,
   output logic                           inst_resp_hit,
   input  logic                           data_req_valid,
   input  logic                           data_req_write,
   input  logic [mem_sys_pkg::ADDR_W-1:0] data_req_addr,
   input  logic [mem_sys_pkg::DATA_W-1:0] data_req_wdata,
   output logic                           data_req_ready,
   output logic                           data_resp_valid,
   output logic [mem_sys_pkg::DATA_W-1:0] data_resp_rdata,
   output logic                           data_resp_hit
);
   import mem_sys_pkg::*;

   logic              i_valid, i_write, i_ready, i_rvalid;
   logic [ADDR_W-1:0] i_addr;
   logic [DATA_W-1:0] i_wdata, i_rdata;
   logic              d_valid, d_write, d_ready, d_rvalid;
   logic [ADDR_W-1:0] d_addr;
   logic [DATA_W-1:0] d_wdata, d_rdata;
   logic              mem_valid, mem_write, mem_ready, mem_rvalid;
   logic [ADDR_W-1:0] mem_addr;
   logic [DATA_W-1:0] mem_wdata, mem_rdata;

   mem_system inst_cache (
      .clk(clk), .rst(rst), .req_valid(inst_req_valid), .req_write(inst_req_write),
      .req_addr(inst_req_addr), .req_wdata(inst_req_wdata), .req_ready(inst_req_ready),
      .resp_valid(inst_resp_valid), .resp_rdata(inst_resp_rdata), .resp_hit(inst_resp_hit),
      .m_valid(i_valid), .m_write(i_write), .m_addr(i_addr), .m_wdata(i_wdata),
      .m_ready(i_ready), .m_rvalid(i_rvalid), .m_rdata(i_rdata)
   );

   mem_system data_cache (
      .clk(clk), .rst(rst), .req_valid(data_req_valid), .req_write(data_req_write),
      .req_addr(data_req_addr), .req_wdata(data_req_wdata), .req_ready(data_req_ready),
      .resp_valid(data_resp_valid), .resp_rdata(data_resp_rdata), .resp_hit(data_resp_hit),
      .m_valid(d_valid), .m_write(d_write), .m_addr(d_addr), .m_wdata(d_wdata),
      .m_ready(d_ready), .m_rvalid(d_rvalid), .m_rdata(d_rdata)
   );

   // client 0 is inst, client 1 is data
   mem_arbiter arb (
      .clk(clk), .rst(rst),
      .c0_valid(i_valid), .c0_write(i_write), .c0_addr(i_addr), .c0_wdata(i_wdata),
      .c0_ready(i_ready), .c0_rvalid(i_rvalid), .c0_rdata(i_rdata),
      .c1_valid(d_valid), .c1_write(d_write), .c1_addr(d_addr), .c1_wdata(d_wdata),
      .c1_ready(d_ready), .c1_rvalid(d_rvalid), .c1_rdata(d_rdata),
      .valid(mem_valid), .write(mem_write), .addr(mem_addr), .wdata(mem_wdata),
      .ready(mem_ready), .rvalid(mem_rvalid), .rdata(mem_rdata)
   );

   banked_mem mem (
      .clk(clk), .rst(rst), .valid(mem_valid), .write(mem_write), .addr(mem_addr),
      .wdata(mem_wdata), .ready(mem_ready), .rvalid(mem_rvalid), .rdata(mem_rdata)
   );

endmodule

/* tests/tb_clock.sv */
// tb_clock: free-running testbench clock with a 100 ns period
module tb_clock (
   output logic clk
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int HALF_NS = 50;

   initial begin
      clk = 1'b0;
      forever #(HALF_NS) clk = ~clk;
   end

endmodule

/* tests/mem_top_asserts.sv */
// mem_top_asserts: shared memory port checks on bank spacing, read latency and grants
module mem_top_asserts (
   input logic                           clk,
   input logic                           rst,
   input logic                           valid,
   input logic                           write,
   input logic [mem_sys_pkg::ADDR_W-1:0] addr,
   input logic                           ready,
   input logic                           rvalid,
   input logic                           c0_valid,
   input logic                           c1_valid,
   input logic                           c0_ready,
   input logic                           c1_ready
);
   timeunit 1ns;
   timeprecision 1ps;
   import mem_sys_pkg::*;

   localparam int BANK_W = $clog2(NUM_BANKS);

   logic accept;

   assign accept = valid & ready;

   // no bank takes a second access within its busy window
   for (genvar k = 1; k < BANK_BUSY; k++) begin : g_bank_gap
      assert property (@(posedge clk) disable iff (rst)
         accept |-> !($past(accept, k) && $past(addr[BANK_W-1:0], k) == addr[BANK_W-1:0]))
         else $error("bank %0d accepted an access %0d cycles after the previous one",
                     addr[BANK_W-1:0], k);
   end

   assert property (@(posedge clk) disable iff (rst) (accept && !write) |-> ##MEM_LAT rvalid)
      else $error("no read data %0d cycles after an accepted read", MEM_LAT);

   assert property (@(posedge clk) disable iff (rst) rvalid |-> $past(accept && !write, MEM_LAT))
      else $error("read data returned without a matching read");

   // winner of one contended cycle yields the next contended one
   assert property (@(posedge clk) disable iff (rst)
      (c0_valid && c1_valid && $past(c0_valid && c1_valid && ready))
         |-> !(c0_ready && $past(c0_ready)) && !(c1_ready && $past(c1_ready)))
      else $error("one client won two contended cycles in a row");

endmodule

bind mem_arbiter mem_top_asserts asserts (
   .clk(clk), .rst(rst), .valid(valid), .write(write), .addr(addr), .ready(ready),
   .rvalid(rvalid), .c0_valid(c0_valid), .c1_valid(c1_valid),
   .c0_ready(c0_ready), .c1_ready(c1_ready)
);

/* tests/mem_top_tb.sv */
// mem_top_tb: directed and random tests of the two-client cached memory subsystem
module mem_top_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import mem_sys_pkg::*;

   localparam int CLK_NS     = 100;
   // requests over all tests, and the cycle bound for each
   localparam int NUM_REQ    = 448;
   localparam int REQ_CYCLES = 40;
   localparam int SETS       = 2 ** INDEX_W;

   logic                   clk;
   logic                   rst;
   logic [1:0]             req_valid;
   logic [1:0]             req_write;
   logic [1:0][ADDR_W-1:0] req_addr;
   logic [1:0][DATA_W-1:0] req_wdata;
   logic [1:0]             req_ready;
   logic [1:0]             resp_valid;
   logic [1:0][DATA_W-1:0] resp_rdata;
   logic [1:0]             resp_hit;

   // reference memory and which words hold a known value
   logic [DATA_W-1:0] ref_mem [2**ADDR_W];
   bit                ref_known [2**ADDR_W];
   // per-port cache model, index 0 is inst
   logic [TAG_W-1:0]  mtag [2][SETS][2];
   bit                mval [2][SETS][2];
   bit                mlru [2][SETS];
   // responses in flight per port as {known, hit, data}
   logic [DATA_W+1:0] exp_q [2][4];
   int                exp_wr [2];
   int                exp_rd [2];
   int                accepts [2];
   int                resps [2];
   int                checks;
   int                errors;

   tb_clock clock_gen (.clk(clk));

   mem_top dut (
      .clk(clk), .rst(rst),
      .inst_req_valid(req_valid[0]), .inst_req_write(req_write[0]),
      .inst_req_addr(req_addr[0]), .inst_req_wdata(req_wdata[0]),
      .inst_req_ready(req_ready[0]), .inst_resp_valid(resp_valid[0]),
      .inst_resp_rdata(resp_rdata[0]), .inst_resp_hit(resp_hit[0]),
      .data_req_valid(req_valid[1]), .data_req_write(req_write[1]),
      .data_req_addr(req_addr[1]), .data_req_wdata(req_wdata[1]),
      .data_req_ready(req_ready[1]), .data_resp_valid(resp_valid[1]),
      .data_resp_rdata(resp_rdata[1]), .data_resp_hit(resp_hit[1])
   );

   always @(posedge clk) begin
      if (!rst) begin
         for (int p = 0; p < 2; p++) begin
            if (req_valid[p] && req_ready[p]) begin
               accepts[p] = accepts[p] + 1;
            end
            if (resp_valid[p]) begin
               resps[p] = resps[p] + 1;
            end
         end
      end
   end

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
         errors++;
      end
   endtask

   function automatic logic [ADDR_W-1:0] line_addr(input int tag, input int idx, input int off);
      return {TAG_W'(tag), INDEX_W'(idx), OFFSET_W'(off)};
   endfunction

   // returns whether the line was resident, then updates tags and lru
   function automatic logic model_access(input int p, input logic [ADDR_W-1:0] a);
      logic [TAG_W-1:0]   tag;
      logic [INDEX_W-1:0] idx;
      int                 way;
      tag = a[ADDR_W-1 -: TAG_W];
      idx = a[OFFSET_W +: INDEX_W];
      for (int w = 0; w < 2; w++) begin
         if (mval[p][idx][w] && mtag[p][idx][w] == tag) begin
            mlru[p][idx] = (w == 0);
            return 1'b1;
         end
      end
      // empty way first, else the less recently used one
      if (!mval[p][idx][0]) begin
         way = 0;
      end else if (!mval[p][idx][1]) begin
         way = 1;
      end else begin
         way = int'(mlru[p][idx]);
      end
      mval[p][idx][way] = 1'b1;
      mtag[p][idx][way] = tag;
      mlru[p][idx] = (way == 0);
      return 1'b0;
   endfunction

   // called on a falling edge, holds the request until it is taken
   task automatic send(input int p, input logic wr, input logic [ADDR_W-1:0] a,
                       input logic [DATA_W-1:0] d);
      logic hit;
      req_valid[p] = 1'b1;
      req_write[p] = wr;
      req_addr[p]  = a;
      req_wdata[p] = d;
      while (!req_ready[p]) @(negedge clk);
      hit = model_access(p, a);
      if (wr) begin
         ref_mem[a]   = d;
         ref_known[a] = 1'b1;
      end
      exp_q[p][exp_wr[p]] = {ref_known[a], hit, ref_mem[a]};
      exp_wr[p] = (exp_wr[p] + 1) % 4;
      @(negedge clk);
      req_valid[p] = 1'b0;
   endtask

   task automatic receive(input int p, input string name);
      logic [DATA_W+1:0] e;
      while (!resp_valid[p]) @(negedge clk);
      e = exp_q[p][exp_rd[p]];
      exp_rd[p] = (exp_rd[p] + 1) % 4;
      check({name, " hit"}, e[DATA_W], resp_hit[p]);
      if (e[DATA_W+1]) begin
         check({name, " data"}, e[DATA_W-1:0], resp_rdata[p]);
      end
      @(negedge clk);
   endtask

   task automatic access(input int p, input logic wr, input logic [ADDR_W-1:0] a,
                         input logic [DATA_W-1:0] d, input string name);
      send(p, wr, a, d);
      receive(p, name);
   endtask

   task automatic test_fresh_line();
      access(1, 1'b1, line_addr(8, 5, 1), 16'h1234, "fresh write");
      access(1, 1'b0, line_addr(8, 5, 1), '0, "fresh read");
      access(1, 1'b0, line_addr(8, 5, 2), '0, "fresh other word");
   endtask

   // third line in one set pushes out the dirty lru line
   task automatic test_eviction();
      for (int t = 9; t < 12; t++) begin
         access(1, 1'b1, line_addr(t, 10, 0), 16'(t * 16'h1111), "evict write");
      end
      access(1, 1'b0, line_addr(9, 10, 0), '0, "evict reread");
   endtask

   task automatic test_lru_keep();
      int tags [7] = '{1, 2, 1, 3, 1, 2, 3};
      bit wrs [7]  = '{1, 1, 0, 1, 0, 0, 0};
      for (int i = 0; i < 7; i++) begin
         access(0, wrs[i], line_addr(tags[i], 20, 3), 16'(16'h0a00 + i), "lru keep");
      end
   endtask

   task automatic burst(input int p, input int tag_base);
      logic [DATA_W-1:0] d;
      for (int i = 0; i < 8; i++) begin
         d = 16'($urandom);
         access(p, 1'b1, line_addr(tag_base + i % 4, 30, i % 4), d, "both ports write");
         access(p, 1'b0, line_addr(tag_base + i % 4, 30, i % 4), '0, "both ports read");
      end
   endtask

   // same sets and banks on both ports, disjoint tags
   task automatic test_both_ports();
      fork
         burst(0, 4);
         burst(1, 12);
      join
   endtask

   task automatic random_port(input int p, input int n);
      logic [ADDR_W-1:0] a;
      for (int i = 0; i < n; i++) begin
         a = line_addr(p * 8 + $urandom_range(0, 7), $urandom_range(0, 3), $urandom_range(0, 3));
         access(p, 1'($urandom_range(0, 1)), a, 16'($urandom), "random");
         repeat ($urandom_range(0, 3)) @(negedge clk);
      end
   endtask

   task automatic test_random();
      fork
         random_port(0, 200);
         random_port(1, 200);
      join
   endtask

   // second request waits on the port while the first one misses
   task automatic test_hold();
      send(1, 1'b1, line_addr(13, 40, 2), 16'hbeef);
      check("hold ready low", 0, req_ready[1]);
      fork
         send(1, 1'b0, line_addr(13, 40, 2), '0);
         receive(1, "hold first");
      join
      receive(1, "hold second");
   endtask

   initial begin
      #(NUM_REQ * REQ_CYCLES * CLK_NS);
      $display("Timeout: tests did not finish within %0d cycles", NUM_REQ * REQ_CYCLES);
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      void'($urandom(96));
      rst       = 1'b1;
      req_valid = '0;
      req_write = '0;
      req_addr  = '0;
      req_wdata = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      test_fresh_line();
      test_eviction();
      test_lru_keep();
      test_both_ports();
      test_random();
      test_hold();
      for (int p = 0; p < 2; p++) begin
         check($sformatf("port %0d responses", p), accepts[p], resps[p]);
      end
      $display("Checks: %0d, mismatches: %0d", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* filelist.f */
source/mem_sys_pkg.sv
source/cache_way.sv
source/cache_ctrl.sv
source/mem_system.sv
source/mem_arbiter.sv
source/banked_mem.sv
source/mem_top.sv
tests/tb_clock.sv
tests/mem_top_asserts.sv
tests/mem_top_tb.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - files:
      - source/mem_sys_pkg.sv
      - source/cache_way.sv
      - source/cache_ctrl.sv
      - source/mem_system.sv
      - source/mem_arbiter.sv
      - source/banked_mem.sv
      - source/mem_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/mem_top_asserts.sv
      - tests/mem_top_tb.sv
